// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = ex_stage_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator status is ignored, the log decides
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module alu (
  input  wire logic [`EX_WORD_W-1:0] opa,
  input  wire logic [`EX_WORD_W-1:0] opb,
  input  wire logic [`EX_WORD_W-1:0] rega,   // tested by branches
  input  wire logic [`EX_FUNC_W-1:0] func,
  input  wire ex_pkg::ex_ir_t        ir,
  output logic      [`EX_WORD_W-1:0] result,
  output logic                       brcond
);

  logic [5:0] shamt;
  logic       lt_u;
  logic       lt_s;
  logic       eq;
  logic       cond_raw;

  ////////////////////////////////////////////////////////////
  // function unit

  assign shamt = opb[5:0];                   // only six bits count
  assign lt_u  = (opa < opb);
  assign lt_s  = ($signed(opa) < $signed(opb));
  assign eq    = (opa == opb);

  always_comb
  begin
    case (func)
      `EX_ALU_ADDQ:   result = opa + opb;
      `EX_ALU_SUBQ:   result = opa - opb;
      `EX_ALU_AND:    result = opa & opb;
      `EX_ALU_BIC:    result = opa & ~opb;
      `EX_ALU_BIS:    result = opa | opb;
      `EX_ALU_ORNOT:  result = opa | ~opb;
      `EX_ALU_XOR:    result = opa ^ opb;
      `EX_ALU_EQV:    result = ~(opa ^ opb);
      `EX_ALU_SRL:    result = opa >> shamt;
      `EX_ALU_SLL:    result = opa << shamt;
      `EX_ALU_SRA:    result = $signed(opa) >>> shamt;  // sign filled
      `EX_ALU_CMPULT: result = {{(`EX_WORD_W-1){1'b0}}, lt_u};
      `EX_ALU_CMPEQ:  result = {{(`EX_WORD_W-1){1'b0}}, eq};
      `EX_ALU_CMPLT:  result = {{(`EX_WORD_W-1){1'b0}}, lt_s};
      `EX_ALU_CMPLE:  result = {{(`EX_WORD_W-1){1'b0}}, lt_s | eq};
      default:        result = `EX_OPB_POISON;  // undefined function
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch condition

  // the compiler uses the opcode low bits as the test,
  // opcode bit 28 flips the sense (beq/bne, blt/bge ...)
  always_comb
  begin
    case (ir.br.opcode[1:0])
      2'd0: cond_raw = ~rega[0];                       // blbc
      2'd1: cond_raw = (rega == '0);                   // beq
      2'd2: cond_raw = rega[`EX_WORD_W-1];             // blt
      2'd3: cond_raw = rega[`EX_WORD_W-1] | (rega == '0);  // ble
    endcase
  end

  assign brcond = cond_raw ^ ir.br.opcode[2];

endmodule

`default_nettype wire

// ==== design/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// datapath widths
`define EX_WORD_W        64          // data and pc
`define EX_IR_W          32          // instruction word
`define EX_REG_IDX_W     6           // destination register index
`define EX_ZERO_REG      6'd31       // r31 reads as zero

////////////////////////////////////////////////////////////
// operand mux selects from decode
`define EX_SEL_W         2
`define EX_OPA_IS_REGA       2'd0
`define EX_OPA_IS_MEM_DISP   2'd1
`define EX_OPA_IS_NPC        2'd2
`define EX_OPA_IS_NOT3       2'd3    // address alignment mask
`define EX_OPB_IS_REGB       2'd0
`define EX_OPB_IS_ALU_IMM    2'd1
`define EX_OPB_IS_BR_DISP    2'd2    // code 3 reserved
`define EX_OPB_POISON        64'hbaadbeefdeadbeef

////////////////////////////////////////////////////////////
// alu function codes
`define EX_FUNC_W        5
`define EX_ALU_ADDQ      5'd0
`define EX_ALU_SUBQ      5'd1
`define EX_ALU_AND       5'd2
`define EX_ALU_BIC       5'd3
`define EX_ALU_BIS       5'd4
`define EX_ALU_ORNOT     5'd5
`define EX_ALU_XOR       5'd6
`define EX_ALU_EQV       5'd7
`define EX_ALU_SRL       5'd8
`define EX_ALU_SLL       5'd9
`define EX_ALU_SRA       5'd10
`define EX_ALU_CMPULT    5'd11
`define EX_ALU_CMPEQ     5'd12
`define EX_ALU_CMPLT     5'd13
`define EX_ALU_CMPLE     5'd14

`define EX_MULT_STAGES   8           // default multiplier depth

`endif

// ==== design/ex_pkg.sv ====
`default_nettype none
`include "ex_macros.svh"

package ex_pkg;

  // loads, stores and lda
  typedef struct packed {
    logic [5:0]         opcode;
    logic [4:0]         ra;
    logic [4:0]         rb;
    logic signed [15:0] disp;   // byte offset
  } ex_mem_fmt_t;

  typedef struct packed {
    logic [5:0]         opcode; // [2] inverts, [1:0] picks condition
    logic [4:0]         ra;
    logic signed [20:0] disp;   // longword offset
  } ex_br_fmt_t;

  // operate format, literal form
  typedef struct packed {
    logic [5:0]         opcode;
    logic [4:0]         ra;
    logic [7:0]         lit;    // zero extended
    logic               lit_flag;
    logic [6:0]         func;
    logic [4:0]         rc;
  } ex_opr_fmt_t;

  typedef union packed {
    logic [`EX_IR_W-1:0] raw;
    ex_mem_fmt_t         mem;
    ex_br_fmt_t          br;
    ex_opr_fmt_t         opr;
  } ex_ir_t;

endpackage

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_stage (
  input  wire logic                     clock,
  input  wire logic                     reset,
  // integer lane
  input  wire logic [`EX_WORD_W-1:0]    alu_npc,
  input  wire ex_pkg::ex_ir_t           alu_ir,
  input  wire logic [`EX_WORD_W-1:0]    alu_rega,
  input  wire logic [`EX_WORD_W-1:0]    alu_regb,
  input  wire logic [`EX_REG_IDX_W-1:0] alu_dest,
  input  wire logic [`EX_SEL_W-1:0]     alu_opa_select,
  input  wire logic [`EX_SEL_W-1:0]     alu_opb_select,
  input  wire logic [`EX_FUNC_W-1:0]    alu_func,
  input  wire logic                     rd_mem,
  input  wire logic                     wr_mem,
  input  wire logic                     cond_branch,
  input  wire logic                     uncond_branch,
  input  wire logic                     alu_valid,
  // multiply lane
  input  wire logic [`EX_WORD_W-1:0]    mul_npc,
  input  wire ex_pkg::ex_ir_t           mul_ir,
  input  wire logic [`EX_WORD_W-1:0]    mul_rega,
  input  wire logic [`EX_WORD_W-1:0]    mul_regb,
  input  wire logic [`EX_REG_IDX_W-1:0] mul_dest,
  input  wire logic [`EX_SEL_W-1:0]     mul_opa_select,
  input  wire logic [`EX_SEL_W-1:0]     mul_opb_select,
  input  wire logic                     mul_valid,
  // results
  output logic      [`EX_WORD_W-1:0]    alu_npc_out,
  output logic      [`EX_WORD_W-1:0]    alu_result_out,
  output logic      [`EX_WORD_W-1:0]    take_branch_target,
  output logic                          take_branch,
  output logic                          rd_mem_out,
  output logic                          wr_mem_out,
  output logic                          alu_valid_out,
  output logic      [`EX_REG_IDX_W-1:0] alu_dest_out,
  output logic      [`EX_WORD_W-1:0]    mul_npc_out,
  output logic      [`EX_WORD_W-1:0]    mul_product,
  output logic                          mul_valid_out,
  output logic      [`EX_REG_IDX_W-1:0] mul_dest_out
);

  logic [`EX_WORD_W-1:0] int_opa, int_opb;
  logic [`EX_WORD_W-1:0] int_result;
  logic                  int_brcond;
  logic [`EX_WORD_W-1:0] mul_opa, mul_opb;

  ////////////////////////////////////////////////////////////
  // integer lane, same cycle

  operand_select int_ops (.npc(alu_npc), .ir(alu_ir), .rega(alu_rega), .regb(alu_regb),
                          .opa_select(alu_opa_select), .opb_select(alu_opb_select),
                          .opa(int_opa), .opb(int_opb));

  alu int_alu (.opa(int_opa), .opb(int_opb), .rega(alu_rega), .func(alu_func), .ir(alu_ir),
               .result(int_result), .brcond(int_brcond));

  assign alu_valid_out      = alu_valid;
  assign alu_npc_out        = alu_npc;
  assign alu_result_out     = !alu_valid    ? '0 :
                              uncond_branch ? alu_npc :     // link address
                                              int_result;
  assign take_branch_target = alu_valid ? int_result : '0;  // target from npc + disp
  assign take_branch        = alu_valid & (uncond_branch | (cond_branch & int_brcond));
  assign rd_mem_out         = alu_valid & rd_mem;
  assign wr_mem_out         = alu_valid & wr_mem;
  assign alu_dest_out       = (rd_mem | wr_mem) ? `EX_ZERO_REG : alu_dest;  // no writeback

  ////////////////////////////////////////////////////////////
  // multiply lane

  operand_select mul_ops (.npc(mul_npc), .ir(mul_ir), .rega(mul_rega), .regb(mul_regb),
                          .opa_select(mul_opa_select), .opb_select(mul_opb_select),
                          .opa(mul_opa), .opb(mul_opb));

  pipe_mult #(.MULT_STAGES(`EX_MULT_STAGES)) mult (
    .clock(clock), .reset(reset), .mplier(mul_opa), .mcand(mul_opb),
    .valid(mul_valid), .dest(mul_dest), .npc(mul_npc),
    .product(mul_product), .valid_out(mul_valid_out),
    .dest_out(mul_dest_out), .npc_out(mul_npc_out));

endmodule

`default_nettype wire

// ==== design/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module operand_select (
  input  wire logic [`EX_WORD_W-1:0] npc,        // pc + 4
  input  wire ex_pkg::ex_ir_t        ir,
  input  wire logic [`EX_WORD_W-1:0] rega,
  input  wire logic [`EX_WORD_W-1:0] regb,
  input  wire logic [`EX_SEL_W-1:0]  opa_select,
  input  wire logic [`EX_SEL_W-1:0]  opb_select,
  output logic      [`EX_WORD_W-1:0] opa,
  output logic      [`EX_WORD_W-1:0] opb
);

  logic [`EX_WORD_W-1:0] mem_disp;
  logic [`EX_WORD_W-1:0] br_disp;
  logic [`EX_WORD_W-1:0] alu_imm;

  // immediates, one per instruction format
  assign mem_disp = {{(`EX_WORD_W-16){ir.mem.disp[15]}}, ir.mem.disp};
  assign br_disp  = {{(`EX_WORD_W-23){ir.br.disp[20]}}, ir.br.disp, 2'b00};  // to bytes
  assign alu_imm  = {{(`EX_WORD_W-8){1'b0}}, ir.opr.lit};

  always_comb
  begin
    case (opa_select)
      `EX_OPA_IS_REGA:     opa = rega;
      `EX_OPA_IS_MEM_DISP: opa = mem_disp;
      `EX_OPA_IS_NPC:      opa = npc;
      `EX_OPA_IS_NOT3:     opa = ~64'h3;  // clears low two bits
    endcase
  end

  always_comb
  begin
    case (opb_select)
      `EX_OPB_IS_REGB:    opb = regb;
      `EX_OPB_IS_ALU_IMM: opb = alu_imm;
      `EX_OPB_IS_BR_DISP: opb = br_disp;
      default:            opb = `EX_OPB_POISON;  // reserved select
    endcase
  end

endmodule

`default_nettype wire

// ==== design/pipe_mult.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module pipe_mult #(
  parameter int MULT_STAGES = `EX_MULT_STAGES  // must divide the word width
) (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic [`EX_WORD_W-1:0]    mplier,
  input  wire logic [`EX_WORD_W-1:0]    mcand,
  input  wire logic                     valid,
  input  wire logic [`EX_REG_IDX_W-1:0] dest,
  input  wire logic [`EX_WORD_W-1:0]    npc,
  output logic      [`EX_WORD_W-1:0]    product,
  output logic                          valid_out,
  output logic      [`EX_REG_IDX_W-1:0] dest_out,
  output logic      [`EX_WORD_W-1:0]    npc_out
);

  localparam int SLICE_W = `EX_WORD_W / MULT_STAGES;  // multiplier bits per stage

  logic [`EX_WORD_W-1:0]    psum_q   [0:MULT_STAGES-1];
  logic [`EX_WORD_W-1:0]    mcand_q  [0:MULT_STAGES-1];
  logic [`EX_WORD_W-1:0]    mplier_q [0:MULT_STAGES-1];
  logic                     valid_q  [0:MULT_STAGES-1];
  logic [`EX_REG_IDX_W-1:0] dest_q   [0:MULT_STAGES-1];
  logic [`EX_WORD_W-1:0]    npc_q    [0:MULT_STAGES-1];

  ////////////////////////////////////////////////////////////
  // datapath, one multiplier slice per stage

  always_ff @(posedge clock)
  begin
    psum_q[0]   <= mcand * mplier[SLICE_W-1:0];  // low product only
    mcand_q[0]  <= mcand << SLICE_W;
    mplier_q[0] <= mplier >> SLICE_W;
    dest_q[0]   <= dest;
    npc_q[0]    <= npc;
    for (int i = 1; i < MULT_STAGES; i++)
    begin
      psum_q[i]   <= psum_q[i-1] + mcand_q[i-1] * mplier_q[i-1][SLICE_W-1:0];
      mcand_q[i]  <= mcand_q[i-1] << SLICE_W;    // align to next slice
      mplier_q[i] <= mplier_q[i-1] >> SLICE_W;
      dest_q[i]   <= dest_q[i-1];
      npc_q[i]    <= npc_q[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // valid chain, bubbles travel with their slot

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < MULT_STAGES; i++)
      begin
        valid_q[i] <= 1'b0;
      end
    end
    else
    begin
      valid_q[0] <= valid;
      for (int i = 1; i < MULT_STAGES; i++)
      begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign product   = psum_q[MULT_STAGES-1];
  assign valid_out = valid_q[MULT_STAGES-1];
  assign dest_out  = dest_q[MULT_STAGES-1];
  assign npc_out   = npc_q[MULT_STAGES-1];

endmodule

`default_nettype wire

// ==== verif/ex_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_stage_tb;
  import ex_pkg::*;

  localparam int N_OP   = 150;  // operate instructions
  localparam int N_BR   = 64;   // conditional branches
  localparam int N_UNC  = 16;
  localparam int N_GATE = 48;   // invalid, loads and stores
  localparam int N_VEC  = N_OP + N_BR + N_UNC + N_GATE;
  localparam int WATCHDOG_NS = (N_VEC + `EX_MULT_STAGES + 20) * 10;

  typedef struct packed {
    logic                     valid;
    logic [`EX_WORD_W-1:0]    product;
    logic [`EX_REG_IDX_W-1:0] dest;
    logic [`EX_WORD_W-1:0]    npc;
  } mul_item_t;

  logic clock, reset;
  logic [`EX_WORD_W-1:0] alu_npc, alu_rega, alu_regb, mul_npc, mul_rega, mul_regb;
  ex_ir_t alu_ir, mul_ir;
  logic [`EX_REG_IDX_W-1:0] alu_dest, mul_dest, alu_dest_out, mul_dest_out;
  logic [`EX_SEL_W-1:0] alu_opa_select, alu_opb_select, mul_opa_select, mul_opb_select;
  logic [`EX_FUNC_W-1:0] alu_func;
  logic rd_mem, wr_mem, cond_branch, uncond_branch, alu_valid, mul_valid;
  logic [`EX_WORD_W-1:0] alu_npc_out, alu_result_out, take_branch_target;
  logic [`EX_WORD_W-1:0] mul_npc_out, mul_product;
  logic take_branch, rd_mem_out, wr_mem_out, alu_valid_out, mul_valid_out;

  logic [63:0] rng_state = 64'd87641;
  logic [`EX_WORD_W-1:0] exp_result, exp_target;
  logic exp_take;
  mul_item_t mul_next, mul_head;
  mul_item_t mul_queue [$];  // one entry per cycle in flight

  ex_stage dut (.*);

  always #5 clock = ~clock;

  ////////////////////////////////////////////////////////////
  // reference model

  function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic logic [63:0] model_opa(input logic [1:0] sel, input logic [63:0] npc,
                                            input logic [31:0] ir, input logic [63:0] rega);
    case (sel)
      2'd0:    return rega;
      2'd1:    return {{48{ir[15]}}, ir[15:0]};  // memory displacement
      2'd2:    return npc;
      default: return 64'hffff_ffff_ffff_fffc;
    endcase
  endfunction

  function automatic logic [63:0] model_opb(input logic [1:0] sel, input logic [31:0] ir,
                                            input logic [63:0] regb);
    case (sel)
      2'd0:    return regb;
      2'd1:    return {56'd0, ir[20:13]};               // literal
      2'd2:    return {{41{ir[20]}}, ir[20:0], 2'b00};  // branch disp in bytes
      default: return 64'hbaad_beef_dead_beef;
    endcase
  endfunction

  function automatic logic [63:0] model_alu(input logic [4:0] func, input logic [63:0] a, b);
    logic [5:0] sh;
    sh = b[5:0];
    case (func)
      `EX_ALU_ADDQ:   return a + b;
      `EX_ALU_SUBQ:   return a + ~b + 64'd1;
      `EX_ALU_AND:    return a & b;
      `EX_ALU_BIC:    return a & ~b;
      `EX_ALU_BIS:    return a | b;
      `EX_ALU_ORNOT:  return a | ~b;
      `EX_ALU_XOR:    return a ^ b;
      `EX_ALU_EQV:    return a ~^ b;
      `EX_ALU_SRL:    return a >> sh;
      `EX_ALU_SLL:    return a << sh;
      `EX_ALU_SRA:    return (a >> sh) | (a[63] ? ~(~64'd0 >> sh) : 64'd0);  // fill high bits
      `EX_ALU_CMPULT: return {63'd0, a < b};
      `EX_ALU_CMPEQ:  return {63'd0, a == b};
      `EX_ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
      `EX_ALU_CMPLE:  return {63'd0, !($signed(b) < $signed(a))};
      default:        return 64'hbaad_beef_dead_beef;
    endcase
  endfunction

  function automatic logic model_brcond(input logic [31:0] ir, input logic [63:0] rega);
    logic c;
    case (ir[27:26])
      2'd0:    c = ~rega[0];
      2'd1:    c = (rega == 64'd0);
      2'd2:    c = rega[63];
      default: c = ($signed(rega) <= 0);
    endcase
    return c ^ ir[28];  // sense flip
  endfunction

  task automatic update_int_expect();
    logic [63:0] res;
    res = model_alu(alu_func, model_opa(alu_opa_select, alu_npc, alu_ir.raw, alu_rega),
                    model_opb(alu_opb_select, alu_ir.raw, alu_regb));
    exp_target = alu_valid ? res : 64'd0;
    exp_result = !alu_valid ? 64'd0 : (uncond_branch ? alu_npc : res);
    exp_take   = alu_valid & (uncond_branch | (cond_branch & model_brcond(alu_ir.raw, alu_rega)));
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
    $display("Verification failed");
    $fatal(1, "%s check failed", what);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  task automatic drive_mul(input logic active);
    logic [63:0] r;
    r = next_rand();
    mul_valid      = active & (r[1:0] != 2'b00);  // about one bubble in four
    mul_opa_select = r[3:2];
    mul_opb_select = r[5:4];
    mul_dest       = r[11:6];
    mul_ir.raw     = r[63:32];
    mul_rega       = next_rand();
    mul_regb       = next_rand();
    r              = next_rand();
    mul_npc        = {r[63:2], 2'b00};
    mul_next.valid   = mul_valid;
    mul_next.product = model_opa(mul_opa_select, mul_npc, mul_ir.raw, mul_rega)
                     * model_opb(mul_opb_select, mul_ir.raw, mul_regb);  // low 64 bits
    mul_next.dest    = mul_dest;
    mul_next.npc     = mul_npc;
  endtask

  // flags are {valid, rd_mem, wr_mem, cond_branch, uncond_branch}
  task automatic step_int(input ex_ir_t ir, input logic [1:0] opa_sel,
                          input logic [1:0] opb_sel, input logic [4:0] func,
                          input logic [4:0] flags, input logic [63:0] rega);
    logic [63:0] r;
    @(negedge clock);
    r = next_rand();
    alu_npc        = {r[63:2], 2'b00};
    alu_dest       = r[7:2];
    alu_regb       = next_rand();
    alu_ir         = ir;
    alu_rega       = rega;
    alu_opa_select = opa_sel;
    alu_opb_select = opb_sel;
    alu_func       = func;
    {alu_valid, rd_mem, wr_mem, cond_branch, uncond_branch} = flags;
    drive_mul(1'b1);
    update_int_expect();
  endtask

  initial
  begin
    logic [63:0] r;
    logic [63:0] rega;
    ex_ir_t ir;
    clock = 1'b0;
    reset = 1'b1;
    {alu_npc, alu_rega, alu_regb, alu_ir, alu_dest} = '0;
    {alu_opa_select, alu_opb_select, alu_func} = '0;
    {rd_mem, wr_mem, cond_branch, uncond_branch, alu_valid} = '0;
    {mul_npc, mul_rega, mul_regb, mul_ir, mul_dest} = '0;
    {mul_opa_select, mul_opb_select, mul_valid} = '0;
    mul_next = '0;
    repeat (`EX_MULT_STAGES)
    begin
      mul_queue.push_back(mul_next);  // empty pipeline after reset
    end
    update_int_expect();
    repeat (3) @(negedge clock);
    reset = 1'b0;

    for (int i = 0; i < N_OP; i++)
    begin
      r = next_rand();
      ir.raw = r[63:32];
      ir.opr.opcode = 6'h11;  // integer operate group
      step_int(ir, r[1:0], {1'b0, r[2]}, 5'(i % 15), 5'b10000, next_rand());
    end

    for (int i = 0; i < N_BR; i++)
    begin
      r = next_rand();
      ir.raw = r[31:0];
      ir.br.opcode = {3'b111, 3'(i % 8)};  // blbc .. bgt
      r = next_rand();
      case ((i / 8) % 4)
        0:       rega = 64'd0;
        1:       rega = 64'd1;
        2:       rega = {1'b1, r[62:0]};
        default: rega = {1'b0, r[62:0]};
      endcase
      step_int(ir, `EX_OPA_IS_NPC, `EX_OPB_IS_BR_DISP, `EX_ALU_ADDQ, 5'b10010, rega);
    end

    for (int i = 0; i < N_UNC; i++)
    begin
      r = next_rand();
      ir.raw = r[31:0];
      ir.br.opcode = 6'h30;
      step_int(ir, `EX_OPA_IS_NPC, `EX_OPB_IS_BR_DISP, `EX_ALU_ADDQ, 5'b10001, next_rand());
    end

    // valid alternates, memory and branch flags random
    for (int i = 0; i < N_GATE; i++)
    begin
      r = next_rand();
      ir.raw = r[63:32];
      step_int(ir, r[1:0], r[3:2], r[8:4] % 5'd15, {i[0], r[10:9], r[12:11]}, next_rand());
    end

    repeat (`EX_MULT_STAGES + 2)
    begin
      @(negedge clock);
      drive_mul(1'b0);  // drain the multiplier
    end
    @(negedge clock);
    $display("Verification passed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // checking

  always @(posedge clock)
  begin
    if (!reset)
    begin
      assert (alu_result_out == exp_result)
        else report_mismatch("alu_result_out", alu_result_out, exp_result);
      assert (take_branch_target == exp_target)
        else report_mismatch("take_branch_target", take_branch_target, exp_target);
      assert (take_branch == exp_take)
        else report_mismatch("take_branch", take_branch, exp_take);
      assert (rd_mem_out == (alu_valid & rd_mem))
        else report_mismatch("rd_mem_out", rd_mem_out, alu_valid & rd_mem);
      assert (wr_mem_out == (alu_valid & wr_mem))
        else report_mismatch("wr_mem_out", wr_mem_out, alu_valid & wr_mem);
      assert (alu_dest_out == ((rd_mem | wr_mem) ? 6'd31 : alu_dest))
        else report_mismatch("alu_dest_out", alu_dest_out, (rd_mem | wr_mem) ? 6'd31 : alu_dest);
      assert (alu_valid_out == alu_valid)
        else report_mismatch("alu_valid_out", alu_valid_out, alu_valid);
      assert (alu_npc_out == alu_npc)
        else report_mismatch("alu_npc_out", alu_npc_out, alu_npc);
      mul_head = mul_queue.pop_front();  // item sampled one pipeline depth ago
      assert (mul_valid_out == mul_head.valid)
        else report_mismatch("mul_valid_out", mul_valid_out, mul_head.valid);
      if (mul_head.valid)
      begin
        assert (mul_product == mul_head.product)
          else report_mismatch("mul_product", mul_product, mul_head.product);
        assert (mul_dest_out == mul_head.dest)
          else report_mismatch("mul_dest_out", mul_dest_out, mul_head.dest);
        assert (mul_npc_out == mul_head.npc)
          else report_mismatch("mul_npc_out", mul_npc_out, mul_head.npc);
      end
      mul_queue.push_back(mul_next);
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/ex_pkg.sv
design/operand_select.sv
design/alu.sv
design/pipe_mult.sv
design/ex_stage.sv
verif/ex_stage_tb.sv
